// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_uart_bridge -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || echo "build or simulation did not complete"
grep -qx "TB PASSED" sim.log 2>/dev/null && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: tb.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_bridge.sv
tb_uart_remote.sv
tb_uart_bridge.sv

// File: tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge import uart_pkg::*; ();

  localparam int NUM_CMDS = 40;
  localparam int SEED = 32'h6e18_3356;
  localparam int WR_CLKS = 2 * FRAME_BITS * CLKS_PER_BIT + 2;
  localparam int TMO_CLKS = FRAME_BITS * CLKS_PER_BIT + RESP_TIMEOUT_CLKS;
  localparam int WATCHDOG_NS =
    NUM_CMDS * (3 * FRAME_BITS * CLKS_PER_BIT + RESP_TIMEOUT_CLKS) * 10 + 200_000;

  logic       clk;
  logic       rst_n;
  uart_cmd_u  cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_vld;
  logic [7:0] read_data;
  logic       read_err;
  logic       bad_par;
  logic       bad_stop;
  logic       silent;
  int         resp_delay;
  logic       byte_vld;
  logic [7:0] byte_data;
  logic       byte_ok;
  logic [7:0] shadow [128];
  logic [7:0] exp_q [$];
  int         cyc;
  int         errors;
  int         tests;
  string      kind_name [5] = '{"write", "read", "read parity fault", "read stop fault",
                                "read silent"};

  uart_bridge i_uart_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  tb_uart_remote i_remote (
    .clk        (clk),
    .tx         (tx),
    .rx         (rx),
    .bad_par    (bad_par),
    .bad_stop   (bad_stop),
    .silent     (silent),
    .resp_delay (resp_delay),
    .byte_vld   (byte_vld),
    .byte_data  (byte_data),
    .byte_ok    (byte_ok)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic check_reset();
    int i;
    int err_before;
    err_before = errors;
    for (i = 0; i < 20; i++) begin
      @(posedge clk);
      if (cmd_rdy !== 1'b1 || tx !== 1'b1) begin
        flag_error($sformatf("cmd_rdy %b tx %b after reset, expected both high", cmd_rdy, tx));
      end
      if (read_vld !== 1'b0 || read_err !== 1'b0) begin
        flag_error("read pulse after reset");
      end
    end
    tests++;
    $display("test 0: reset state, %s", (errors == err_before) ? "ok" : "mismatch");
  endtask

  // kind 0 write, 1 clean read, 2 bad parity, 3 low stop, 4 no answer
  task automatic run_cmd(input int idx, input int kind, input logic [6:0] addr,
                         input logic [7:0] data);
    uart_cmd_u  c;
    int         acc;
    int         junk_at;
    int         lat;
    int         pulse_lat;
    int         n_vld;
    int         n_err;
    int         err_before;
    logic [7:0] rd;
    logic [7:0] e;
    logic [8:0] g;
    logic [8:0] got_q [$];
    c.f.wr     = (kind == 0);
    c.f.addr   = addr;
    c.f.data   = data;
    err_before = errors;
    n_vld      = 0;
    n_err      = 0;
    pulse_lat  = -1;
    rd         = '0;
    do begin
      @(posedge clk);
    end while (!cmd_rdy);
    cmd        <= c;
    cmd_vld    <= 1'b1;
    bad_par    <= (kind == 2);
    bad_stop   <= (kind == 3);
    silent     <= (kind == 4);
    resp_delay <= $urandom_range(1, 10 * CLKS_PER_BIT);
    exp_q.push_back(c.b.hi);
    if (c.f.wr) begin
      exp_q.push_back(c.b.lo);
    end
    @(posedge clk);
    acc     = cyc;
    cmd_vld <= 1'b0;
    junk_at = $urandom_range(2, 10 * CLKS_PER_BIT);
    do begin
      @(posedge clk);
      lat = cyc - acc;
      // stray strobe while busy, well before any transaction can end
      if (lat == junk_at) begin
        cmd     <= 16'($urandom);
        cmd_vld <= 1'b1;
      end else begin
        cmd_vld <= 1'b0;
      end
      if (byte_vld) begin
        got_q.push_back({byte_ok, byte_data});
      end
      if (read_vld) begin
        n_vld++;
        rd        = read_data;
        pulse_lat = lat;
      end
      if (read_err) begin
        n_err++;
        pulse_lat = lat;
      end
    end while (!cmd_rdy);

    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      if (got_q.size() == 0) begin
        flag_error($sformatf("byte %02h never decoded by the remote", e));
      end else begin
        g = got_q.pop_front();
        if (g[7:0] !== e || g[8] !== 1'b1) begin
          flag_error($sformatf("tx byte %02h ok %b, expected %02h with good framing",
                               g[7:0], g[8], e));
        end
      end
    end
    if (got_q.size() != 0) begin
      flag_error($sformatf("%0d extra bytes seen on tx", got_q.size()));
    end

    if (kind == 0) begin
      if (lat != WR_CLKS) begin
        flag_error($sformatf("write took %0d cycles, expected %0d", lat, WR_CLKS));
      end
      if (n_vld != 0 || n_err != 0) begin
        flag_error("read result pulse during a write");
      end
      shadow[addr] = data;
    end else if (kind == 1) begin
      if (n_vld != 1 || n_err != 0) begin
        flag_error($sformatf("read gave %0d read_vld, %0d read_err", n_vld, n_err));
      end else if (rd !== shadow[addr]) begin
        flag_error($sformatf("read_data %02h, expected %02h", rd, shadow[addr]));
      end
    end else begin
      if (n_err != 1 || n_vld != 0) begin
        flag_error($sformatf("faulty read gave %0d read_vld, %0d read_err", n_vld, n_err));
      end
      if (kind == 4 && (lat < TMO_CLKS || lat > TMO_CLKS + 4)) begin
        flag_error($sformatf("timeout after %0d cycles, expected about %0d", lat, TMO_CLKS));
      end
    end
    if (kind != 0 && pulse_lat != lat) begin
      flag_error("cmd_rdy did not return with the read result pulse");
    end
    tests++;
    $display("test %0d: %s addr %02h data %02h, %s", idx, kind_name[kind], addr, data,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int n;
    int r;
    int kind;
    void'($urandom(SEED));
    rst_n      <= 1'b0;
    cmd        <= '0;
    cmd_vld    <= 1'b0;
    bad_par    <= 1'b0;
    bad_stop   <= 1'b0;
    silent     <= 1'b0;
    resp_delay <= 1;
    for (n = 0; n < 128; n++) begin
      shadow[n] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_reset();
    for (n = 1; n <= NUM_CMDS; n++) begin
      r = $urandom_range(0, 9);
      if (r < 4) begin
        kind = 0;
      end else if (r < 7) begin
        kind = 1;
      end else begin
        kind = r - 5;
      end
      run_cmd(n, kind, 7'($urandom_range(0, 15)), 8'($urandom));
      repeat ($urandom_range(0, 20)) @(posedge clk);
    end
    $display("summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: tb_uart_remote.sv
`timescale 1ns/1ps

module tb_uart_remote import uart_pkg::*; (
  input  logic       clk,
  input  logic       tx,
  output logic       rx,
  input  logic       bad_par,
  input  logic       bad_stop,
  input  logic       silent,
  input  int         resp_delay,
  output logic       byte_vld,
  output logic [7:0] byte_data,
  output logic       byte_ok
);

  logic [7:0] regs [128];
  logic [7:0] resp_byte;
  logic       resp_par_bad;
  logic       resp_stop_bad;
  logic       resp_silent;
  int         resp_wait;
  event       send_ev;

  // entered one cycle after the start edge, samples every bit near its middle
  task automatic recv_frame(output logic [7:0] data, output logic ok);
    logic start;
    logic par;
    int   i;
    repeat (HALF_BIT) @(posedge clk);
    start = tx;
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(posedge clk);
    ok = !start && (^{data, par}) && tx;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic par_bad, input logic stop_bad);
    logic [FRAME_BITS-1:0] bits;
    int                    i;
    bits = {~stop_bad, (~^data) ^ par_bad, data, 1'b0};
    for (i = 0; i < FRAME_BITS; i++) begin
      rx <= bits[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  // decoder for frames coming from the bridge
  initial begin
    logic [7:0] b;
    logic       ok;
    logic       prev;
    logic       expect_lo;
    logic [6:0] addr;
    int         i;
    byte_vld  <= 1'b0;
    byte_data <= '0;
    byte_ok   <= 1'b0;
    prev      = 1'b0;
    expect_lo = 1'b0;
    addr      = '0;
    for (i = 0; i < 128; i++) begin
      regs[i] = '0;
    end
    forever begin
      @(posedge clk);
      byte_vld <= 1'b0;
      if (prev && !tx) begin
        recv_frame(b, ok);
        byte_vld  <= 1'b1;
        byte_data <= b;
        byte_ok   <= ok;
        if (expect_lo) begin
          regs[addr] = b;
          expect_lo  = 1'b0;
        end else begin
          addr = b[6:0];
          if (b[7]) begin
            expect_lo = 1'b1;
          end else begin
            resp_byte     = regs[addr];
            resp_par_bad  = bad_par;
            resp_stop_bad = bad_stop;
            resp_silent   = silent;
            resp_wait     = resp_delay;
            ->send_ev;
          end
        end
      end
      prev = tx;
    end
  end

  // read responses on rx
  initial begin
    rx <= 1'b1;
    forever begin
      @(send_ev);
      repeat (resp_wait) @(posedge clk);
      if (!resp_silent) begin
        send_frame(resp_byte, resp_par_bad, resp_stop_bad);
      end
    end
  end

endmodule

// File: uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_u  cmd,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output logic       read_vld,
  output logic [7:0] read_data,
  output logic       read_err
);

  logic            tx_start;
  logic [7:0]      tx_byte;
  logic            tx_done;
  logic            rx_busy;
  logic            rx_strobe;
  uart_rx_result_t rx_result;

  uart_cmd_ctrl i_uart_cmd_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .tx_done   (tx_done),
    .rx_busy   (rx_busy),
    .rx_strobe (rx_strobe),
    .rx_result (rx_result),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx i_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_busy   (rx_busy),
    .rx_strobe (rx_strobe),
    .rx_result (rx_result)
  );

endmodule

// File: uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl import uart_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_cmd_u       cmd,
  input  logic            cmd_vld,
  input  logic            tx_done,
  input  logic            rx_busy,
  input  logic            rx_strobe,
  input  uart_rx_result_t rx_result,
  output logic            cmd_rdy,
  output logic            tx_start,
  output logic [7:0]      tx_byte,
  output logic            read_vld,
  output logic [7:0]      read_data,
  output logic            read_err
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_SEND_LO,
    ST_WAIT_RESP,
    ST_RECV
  } state_t;

  state_t               state;
  uart_cmd_u            cmd_q;
  logic                 launch;
  logic [TMO_CNT_W-1:0] tmo_cnt;
  logic                 resp_bad;

  assign cmd_rdy = (state == ST_IDLE);

  // first byte one cycle after accept, second byte back to back with the first
  assign tx_start = launch || (state == ST_SEND_HI && tx_done && cmd_q.f.wr);
  assign tx_byte  = launch ? cmd_q.b.hi : cmd_q.b.lo;

  assign resp_bad = rx_result.parity_err || rx_result.stop_err;

  always_ff @(posedge clk) begin
    if (cmd_rdy && cmd_vld) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_RECV && rx_strobe) begin
      read_data <= rx_result.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      launch   <= 1'b0;
      tmo_cnt  <= '0;
      read_vld <= 1'b0;
      read_err <= 1'b0;
    end else begin
      launch   <= 1'b0;
      read_vld <= 1'b0;
      read_err <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_vld) begin
            state  <= ST_SEND_HI;
            launch <= 1'b1;
          end
        end
        ST_SEND_HI: begin
          if (tx_done) begin
            if (cmd_q.f.wr) begin
              state <= ST_SEND_LO;
            end else begin
              state   <= ST_WAIT_RESP;
              tmo_cnt <= '0;
            end
          end
        end
        ST_SEND_LO: begin
          if (tx_done) begin
            state <= ST_IDLE;
          end
        end
        ST_WAIT_RESP: begin
          // counter holds while a frame is being received
          if (rx_busy) begin
            state <= ST_RECV;
          end else if (tmo_cnt == TMO_CNT_W'(RESP_TIMEOUT_CLKS - 1)) begin
            state    <= ST_IDLE;
            read_err <= 1'b1;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        ST_RECV: begin
          if (rx_strobe) begin
            state    <= ST_IDLE;
            read_vld <= !resp_bad;
            read_err <= resp_bad;
          end else if (!rx_busy) begin
            // start glitch, keep waiting
            state <= ST_WAIT_RESP;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // transmitter only finishes frames this sequencer started
  a_rdy_not_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && tx_done)
  ) else $error("uart_cmd_ctrl: tx_done while cmd_rdy");

endmodule

// File: uart_pkg.sv
package uart_pkg;

  // 50 MHz system clock, 115200 baud
  localparam int CLKS_PER_BIT = 434;
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  // start, 8 data, parity, stop
  localparam int FRAME_BITS = 11;

  // measured from the read byte's stop bit to the response start edge
  localparam int RESP_TIMEOUT_CLKS = 20 * CLKS_PER_BIT;

  // counter widths
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS + 1);
  localparam int TMO_CNT_W = $clog2(RESP_TIMEOUT_CLKS);

  // command word as seen by the sequencer
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_fields_t;

  // command word as seen on the wire
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } uart_cmd_bytes_t;

  typedef union packed {
    uart_cmd_fields_t f;
    uart_cmd_bytes_t  b;
  } uart_cmd_u;

  // one received frame
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       stop_err;
  } uart_rx_result_t;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output logic            rx_busy,
  output logic            rx_strobe,
  output uart_rx_result_t rx_result
);

  logic [2:0]            rx_dly;
  logic                  rx_sync;
  logic                  rx_fall;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  mid;
  logic [7:0]            data_sh;
  logic                  par_bit;
  logic                  stop_bit;

  // two sync flops plus one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_dly <= 3'b111;
    end else begin
      rx_dly <= {rx_dly[1:0], rx};
    end
  end

  assign rx_sync = rx_dly[1];
  assign rx_fall = rx_dly[2] && !rx_dly[1];

  // sample point in the middle of each bit
  assign mid = rx_busy && !rx_strobe && (baud_cnt == BAUD_CNT_W'(HALF_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy   <= 1'b0;
      rx_strobe <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
    end else begin
      rx_strobe <= 1'b0;
      if (!rx_busy) begin
        if (rx_fall) begin
          rx_busy  <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else if (rx_strobe) begin
        // hold busy through the strobe cycle
        rx_busy <= 1'b0;
      end else begin
        if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
          baud_cnt <= '0;
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (mid) begin
          bit_cnt <= bit_cnt + 1'b1;
          // start bit gone high again, treat as a glitch
          if (bit_cnt == '0 && rx_sync) begin
            rx_busy <= 1'b0;
          end
          if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
            rx_strobe <= 1'b1;
          end
        end
      end
    end
  end

  // frame payload
  always_ff @(posedge clk) begin
    if (mid) begin
      if (bit_cnt >= BIT_CNT_W'(1) && bit_cnt <= BIT_CNT_W'(8)) begin
        data_sh <= {rx_sync, data_sh[7:1]};
      end
      if (bit_cnt == BIT_CNT_W'(9)) begin
        par_bit <= rx_sync;
      end
      if (bit_cnt == BIT_CNT_W'(10)) begin
        stop_bit <= rx_sync;
      end
    end
  end

  // odd parity means the nine bits xor to one
  assign rx_result.data       = data_sh;
  assign rx_result.parity_err = ~^{data_sh, par_bit};
  assign rx_result.stop_err   = ~stop_bit;

  a_strobe_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_strobe |=> !rx_strobe
  ) else $error("uart_rx: rx_strobe high for two cycles");

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  logic [FRAME_BITS-1:0] shreg;
  logic                  busy;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  bit_end;

  assign bit_end = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));

  // last cycle of the stop bit
  assign tx_done = busy && bit_end && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  // line follows the bottom of the shift register, all ones when idle
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg    <= '1;
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tx_start) begin
      // stop, odd parity, data lsb first, start
      shreg    <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[FRAME_BITS-1:1]};
        bit_cnt  <= bit_cnt + 1'b1;
        if (tx_done) begin
          busy <= 1'b0;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // a new frame may only start in the final stop bit cycle or from idle
  a_no_start_mid_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> (!busy || tx_done)
  ) else $error("uart_tx: tx_start while frame in progress");

endmodule
